// ==== dcache_params.svh ====
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Cache geometry
`define DC_LINE_BITS 128
`define DC_NUM_SETS 2
`define DC_NUM_WAYS 2   // LRU logic assumes two ways

// CPU address width
`define DC_ADDR_BITS 32

// 32-bit words in one line, also the APB beat count per line
`define DC_WORDS_PER_LINE 4

`endif

// ==== dcache_pkg.sv ====
package dcache_pkg;

    // Load/store size and direction, funct3 style
    // Stores carry bit 2 set so one code tells load from store
    typedef enum logic [2:0] {
        LB = 3'b000,    // Load byte, sign-extended
        LH = 3'b001,    // Load halfword, sign-extended
        LW = 3'b010,
        SB = 3'b100,
        SH = 3'b101,
        SW = 3'b110
    } access_t;

    // Controller FSM
    typedef enum logic [1:0] {
        IDLE      = 2'b00,  // Accepts requests, serves hits
        WRITEBACK = 2'b01,  // Dirty victim going out
        REFILL    = 2'b10,  // New line coming in
        RESPOND   = 2'b11   // Miss response cycle
    } ctrl_state_t;

endpackage

// ==== dcache_align.sv ====
module dcache_align (
    input  logic [31:0]         word,
    input  logic [1:0]          byte_off,
    input  dcache_pkg::access_t funct3,
    input  logic [31:0]         store_data,
    output logic [31:0]         load_data,
    output logic [31:0]         merged_word
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // Halfwords are aligned, so only bit 1 picks the half
    assign sel_byte = word[byte_off*8 +: 8];
    assign sel_half = word[byte_off[1]*16 +: 16];

    // Load path
    always_comb begin
        case (funct3)
            dcache_pkg::LB: load_data = {{24{sel_byte[7]}}, sel_byte};
            dcache_pkg::LH: load_data = {{16{sel_half[15]}}, sel_half};
            default:        load_data = word;
        endcase
    end

    // Store path
    always_comb begin
        merged_word = word;     // Loads leave the word untouched
        case (funct3)
            dcache_pkg::SB: begin
                merged_word[byte_off*8 +: 8] = store_data[7:0];
            end
            dcache_pkg::SH: begin
                merged_word[byte_off[1]*16 +: 16] = store_data[15:0];
            end
            dcache_pkg::SW: begin
                merged_word = store_data;
            end
            default: begin
                merged_word = word;
            end
        endcase
    end

endmodule

// ==== dcache_ctrl.sv ====
`include "dcache_params.svh"

module dcache_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`DC_ADDR_BITS-1:0] addr,
    input  logic [31:0]              write_data,
    input  logic                     read_en,
    input  logic                     write_en,
    input  dcache_pkg::access_t      funct3,
    input  logic [31:0]              align_load,
    input  logic [31:0]              align_merged,
    input  logic                     line_done,
    input  logic [`DC_LINE_BITS-1:0] line_rdata,
    output logic [31:0]              read_data,
    output logic                     resp_valid,
    output logic                     hit,
    output logic                     busy,
    output logic [31:0]              align_word,
    output logic [1:0]               align_byte_off,
    output dcache_pkg::access_t      align_funct3,
    output logic [31:0]              align_store_data,
    output logic                     line_req,
    output logic                     line_write,
    output logic [`DC_ADDR_BITS-1:0] line_addr,
    output logic [`DC_LINE_BITS-1:0] line_wdata
);

    localparam int NUM_SETS  = `DC_NUM_SETS;
    localparam int NUM_WAYS  = `DC_NUM_WAYS;
    localparam int LINE_BITS = `DC_LINE_BITS;
    localparam int OFF_BITS  = $clog2(LINE_BITS / 8);
    localparam int SET_BITS  = $clog2(NUM_SETS);
    localparam int WORD_BITS = $clog2(`DC_WORDS_PER_LINE);
    localparam int WAY_BITS  = $clog2(NUM_WAYS);
    localparam int TAG_BITS  = `DC_ADDR_BITS - SET_BITS - OFF_BITS;

    logic [LINE_BITS-1:0] data_mem [NUM_SETS][NUM_WAYS];
    logic [TAG_BITS-1:0]  tag_mem  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0]  valid    [NUM_SETS];
    logic [NUM_WAYS-1:0]  dirty    [NUM_SETS];
    logic [WAY_BITS-1:0]  lru      [NUM_SETS];  // Victim way of each set

    dcache_pkg::ctrl_state_t state;

    // Latched request
    logic [`DC_ADDR_BITS-1:0] req_addr;
    logic [31:0]              req_wdata;
    dcache_pkg::access_t      req_funct3;
    logic                     req_store;
    logic [WAY_BITS-1:0]      victim;

    // Live request in IDLE, latched one otherwise
    logic [`DC_ADDR_BITS-1:0] cur_addr;
    logic [TAG_BITS-1:0]      cur_tag;
    logic [SET_BITS-1:0]      cur_set;
    logic [WORD_BITS-1:0]     cur_word;

    logic                 hit_any;
    logic [WAY_BITS-1:0]  hit_way;
    logic [WAY_BITS-1:0]  lru_way;
    logic                 victim_dirty;
    logic                 req_fire;
    logic                 hit_fire;
    logic                 miss_fire;
    logic                 wb_done;
    logic                 refill_done;
    logic [LINE_BITS-1:0] fill_line;

    assign cur_addr = (state == dcache_pkg::IDLE) ? addr : req_addr;
    assign cur_tag  = cur_addr[`DC_ADDR_BITS-1 -: TAG_BITS];
    assign cur_set  = cur_addr[OFF_BITS +: SET_BITS];
    assign cur_word = cur_addr[2 +: WORD_BITS];

    // Tag compare across the ways of the indexed set
    always_comb begin
        hit_any = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid[cur_set][w] && tag_mem[cur_set][w] == cur_tag) begin
                hit_any = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign lru_way      = lru[cur_set];
    assign victim_dirty = valid[cur_set][lru_way] && dirty[cur_set][lru_way];

    // Hit and miss are decided from the same compare, in the request cycle
    assign req_fire    = (state == dcache_pkg::IDLE) && (read_en || write_en);
    assign hit_fire    = req_fire && hit_any;
    assign miss_fire   = req_fire && !hit_any;
    assign wb_done     = (state == dcache_pkg::WRITEBACK) && line_done;
    assign refill_done = (state == dcache_pkg::REFILL) && line_done;

    // Word to the aligner comes from the incoming line during refill
    assign align_word = (state == dcache_pkg::REFILL) ? line_rdata[cur_word*32 +: 32]
                                                      : data_mem[cur_set][hit_way][cur_word*32 +: 32];
    assign align_byte_off   = cur_addr[1:0];
    assign align_funct3     = (state == dcache_pkg::IDLE) ? funct3 : req_funct3;
    assign align_store_data = (state == dcache_pkg::IDLE) ? write_data : req_wdata;

    // Refilled line with a pending store already merged in
    always_comb begin
        fill_line = line_rdata;
        if (req_store) begin
            fill_line[cur_word*32 +: 32] = align_merged;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= dcache_pkg::IDLE;
            busy       <= 1'b0;
            resp_valid <= 1'b0;
            hit        <= 1'b0;
            line_req   <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
                lru[s]   <= '0;
            end
        end else begin
            resp_valid <= 1'b0;     // Single-cycle pulses
            hit        <= 1'b0;
            case (state)
                dcache_pkg::IDLE: begin
                    if (hit_fire) begin
                        resp_valid    <= 1'b1;
                        hit           <= 1'b1;
                        lru[cur_set]  <= ~hit_way;
                        if (write_en) begin
                            dirty[cur_set][hit_way] <= 1'b1;
                        end
                    end else if (miss_fire) begin
                        busy     <= 1'b1;
                        line_req <= 1'b1;
                        state    <= victim_dirty ? dcache_pkg::WRITEBACK : dcache_pkg::REFILL;
                    end
                end
                dcache_pkg::WRITEBACK: begin
                    if (line_done) begin
                        dirty[cur_set][victim] <= 1'b0;
                        state <= dcache_pkg::REFILL;   // line_req stays up for the read
                    end
                end
                dcache_pkg::REFILL: begin
                    if (line_done) begin
                        valid[cur_set][victim] <= 1'b1;
                        dirty[cur_set][victim] <= req_store;
                        lru[cur_set] <= ~victim;
                        line_req     <= 1'b0;
                        busy         <= 1'b0;
                        resp_valid   <= 1'b1;
                        state        <= dcache_pkg::RESPOND;
                    end
                end
                default: begin
                    state <= dcache_pkg::IDLE;
                end
            endcase
        end
    end

    // Arrays, request latch and bridge payload
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_addr   <= addr;
            req_wdata  <= write_data;
            req_funct3 <= funct3;
            req_store  <= write_en;
        end
        if (hit_fire) begin
            if (write_en) begin
                data_mem[cur_set][hit_way][cur_word*32 +: 32] <= align_merged;
            end else begin
                read_data <= align_load;
            end
        end
        if (miss_fire) begin
            victim <= lru_way;
            if (victim_dirty) begin
                line_addr  <= {tag_mem[cur_set][lru_way], cur_set, {OFF_BITS{1'b0}}};
                line_wdata <= data_mem[cur_set][lru_way];
                line_write <= 1'b1;
            end else begin
                line_addr  <= {cur_tag, cur_set, {OFF_BITS{1'b0}}};
                line_write <= 1'b0;
            end
        end
        if (wb_done) begin
            line_addr  <= {cur_tag, cur_set, {OFF_BITS{1'b0}}};  // Now fetch the new line
            line_write <= 1'b0;
        end
        if (refill_done) begin
            data_mem[cur_set][victim] <= fill_line;
            tag_mem[cur_set][victim]  <= cur_tag;
            if (!req_store) begin
                read_data <= align_load;
            end
        end
    end

endmodule

// ==== dcache_apb_bridge.sv ====
`include "dcache_params.svh"

module dcache_apb_bridge (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     line_req,
    input  logic                     line_write,
    input  logic [`DC_ADDR_BITS-1:0] line_addr,
    input  logic [`DC_LINE_BITS-1:0] line_wdata,
    input  logic [31:0]              prdata,
    input  logic                     pready,
    output logic                     line_done,
    output logic [`DC_LINE_BITS-1:0] line_rdata,
    output logic                     psel,
    output logic                     penable,
    output logic                     pwrite,
    output logic [`DC_ADDR_BITS-1:0] paddr,
    output logic [31:0]              pwdata
);

    localparam int WORDS     = `DC_WORDS_PER_LINE;
    localparam int WORD_BITS = $clog2(WORDS);

    logic                 active;   // Line transfer in progress
    logic                 phase;    // 0 setup, 1 access
    logic [WORD_BITS-1:0] cnt;      // Current word of the line
    logic                 beat_done;

    assign beat_done = active && phase && pready;

    // Request fields are held by the controller, so these stay stable
    assign psel    = active;
    assign penable = active && phase;
    assign pwrite  = line_write;
    assign paddr   = line_addr + {cnt, 2'b00};
    assign pwdata  = line_wdata[cnt*32 +: 32];

    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            phase     <= 1'b0;
            cnt       <= '0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            if (!active) begin
                // line_req is still high in the done cycle, skip it
                if (line_req && !line_done) begin
                    active <= 1'b1;
                    phase  <= 1'b0;
                    cnt    <= '0;
                end
            end else if (!phase) begin
                phase <= 1'b1;
            end else if (pready) begin
                phase <= 1'b0;      // Next beat starts with a setup cycle
                cnt   <= cnt + 1'b1;
                if (cnt == WORD_BITS'(WORDS - 1)) begin
                    active    <= 1'b0;
                    line_done <= 1'b1;
                end
            end
        end
    end

    // Assemble read words, word 0 lands in the low bits
    always_ff @(posedge clk) begin
        if (beat_done && !line_write) begin
            line_rdata[cnt*32 +: 32] <= prdata;
        end
    end

endmodule

// ==== dcache_top.sv ====
`include "dcache_params.svh"

module dcache_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`DC_ADDR_BITS-1:0] addr,
    input  logic [31:0]              write_data,
    input  logic                     read_en,
    input  logic                     write_en,
    input  dcache_pkg::access_t      funct3,
    output logic [31:0]              read_data,
    output logic                     resp_valid,
    output logic                     hit,
    output logic                     busy,
    output logic                     psel,
    output logic                     penable,
    output logic                     pwrite,
    output logic [`DC_ADDR_BITS-1:0] paddr,
    output logic [31:0]              pwdata,
    input  logic [31:0]              prdata,
    input  logic                     pready
);

    // Controller to aligner
    logic [31:0]         align_word;
    logic [1:0]          align_byte_off;
    dcache_pkg::access_t align_funct3;
    logic [31:0]         align_store_data;
    logic [31:0]         align_load;
    logic [31:0]         align_merged;

    // Controller to bridge
    logic                     line_req;
    logic                     line_write;
    logic                     line_done;
    logic [`DC_ADDR_BITS-1:0] line_addr;
    logic [`DC_LINE_BITS-1:0] line_wdata;
    logic [`DC_LINE_BITS-1:0] line_rdata;

    dcache_ctrl u_ctrl (
        .clk              (clk),
        .reset            (reset),
        .addr             (addr),
        .write_data       (write_data),
        .read_en          (read_en),
        .write_en         (write_en),
        .funct3           (funct3),
        .align_load       (align_load),
        .align_merged     (align_merged),
        .line_done        (line_done),
        .line_rdata       (line_rdata),
        .read_data        (read_data),
        .resp_valid       (resp_valid),
        .hit              (hit),
        .busy             (busy),
        .align_word       (align_word),
        .align_byte_off   (align_byte_off),
        .align_funct3     (align_funct3),
        .align_store_data (align_store_data),
        .line_req         (line_req),
        .line_write       (line_write),
        .line_addr        (line_addr),
        .line_wdata       (line_wdata)
    );

    dcache_align u_align (
        .word        (align_word),
        .byte_off    (align_byte_off),
        .funct3      (align_funct3),
        .store_data  (align_store_data),
        .load_data   (align_load),
        .merged_word (align_merged)
    );

    dcache_apb_bridge u_bridge (
        .clk        (clk),
        .reset      (reset),
        .line_req   (line_req),
        .line_write (line_write),
        .line_addr  (line_addr),
        .line_wdata (line_wdata),
        .prdata     (prdata),
        .pready     (pready),
        .line_done  (line_done),
        .line_rdata (line_rdata),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata)
    );

endmodule

// ==== tb_clkgen.sv ====
module tb_clkgen #(
    parameter int PERIOD = 40
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Held for two rising edges, released on an edge like the other inputs
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== dcache_checker.sv ====
module dcache_checker #(
    parameter int RESP_LIMIT = 100
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        read_en,
    input  logic        write_en,
    input  logic        resp_valid,
    input  logic        hit,
    input  logic [31:0] read_data,
    input  logic        busy,
    input  int          entry_idx,
    input  logic        exp_hit,
    input  logic [31:0] exp_data,
    input  logic        check_data,
    input  logic        finished,
    input  int          assert_errors,
    output int          error_count
);

    logic pending;
    int   age;          // Cycles since the request was sampled
    int   resp_count;
    logic summary_done;

    initial begin
        error_count  = 0;
        resp_count   = 0;
        pending      = 1'b0;
        age          = 0;
        summary_done = 1'b0;
    end

    always @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else begin
            if (resp_valid) begin
                if (!pending) begin
                    $display("Entry %0d: response without an outstanding request", entry_idx);
                    error_count++;
                end else begin
                    resp_count++;
                    if (hit !== exp_hit) begin
                        $display("[FAIL] entry %0d: hit = 0x%0h, expected 0x%0h",
                                 entry_idx, hit, exp_hit);
                        error_count++;
                    end
                    if (check_data && read_data !== exp_data) begin
                        $display("[FAIL] entry %0d: read_data = 0x%08h, expected 0x%08h",
                                 entry_idx, read_data, exp_data);
                        error_count++;
                    end
                    if (exp_hit && age != 0) begin
                        $display("Entry %0d: hit response came %0d cycles late", entry_idx, age);
                        error_count++;
                    end
                    if (busy) begin
                        $display("Entry %0d: busy still high in the response cycle", entry_idx);
                        error_count++;
                    end
                end
                pending <= 1'b0;
            end else if (pending) begin
                // Busy must rise after the miss and stay up until the response
                if (!exp_hit && !busy) begin
                    $display("Entry %0d: busy low while the miss was outstanding", entry_idx);
                    error_count++;
                end
                if (age == RESP_LIMIT) begin
                    $display("Entry %0d: no response within %0d cycles", entry_idx, RESP_LIMIT);
                    error_count++;
                    pending <= 1'b0;
                end
                age <= age + 1;
            end
            if (read_en || write_en) begin
                pending <= 1'b1;
                age     <= 0;
            end
        end
        if (finished && !summary_done) begin
            if (pending) begin
                $display("Entry %0d: response still outstanding at the end", entry_idx);
                error_count++;
            end
            $display("Responses checked: %0d, checker errors: %0d, assertion failures: %0d",
                     resp_count, error_count, assert_errors);
            summary_done <= 1'b1;
        end
    end

endmodule

// ==== dcache_props.sv ====
`include "dcache_params.svh"

module dcache_props (
    input logic                     clk,
    input logic                     reset,
    input logic                     psel,
    input logic                     penable,
    input logic                     pwrite,
    input logic [`DC_ADDR_BITS-1:0] paddr,
    input logic [31:0]              pwdata,
    input logic                     pready,
    input logic                     busy,
    input dcache_pkg::ctrl_state_t  state
);

    int fail_count = 0;

    // One setup cycle, then the access phase
    setup_then_access: assert property (@(posedge clk) disable iff (reset)
        psel && !penable |=> psel && penable)
        else begin
            $error("penable did not follow psel after one setup cycle");
            fail_count++;
        end

    // Transfer fields frozen until pready ends the access
    hold_while_waiting: assert property (@(posedge clk) disable iff (reset)
        psel && (!penable || !pready) |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata))
        else begin
            $error("paddr, pwrite or pwdata changed while the transfer was waiting");
            fail_count++;
        end

    idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !busy && !psel && state == dcache_pkg::IDLE)
        else begin
            $error("busy, psel or the controller state not idle after reset");
            fail_count++;
        end

endmodule

bind dcache_apb_bridge dcache_props u_apb_props (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pready  (pready),
    .busy    (1'b0),
    .state   (dcache_pkg::IDLE)
);

// Controller side only carries busy and the FSM state
bind dcache_ctrl dcache_props u_ctrl_props (
    .clk     (clk),
    .reset   (reset),
    .psel    (1'b0),
    .penable (1'b0),
    .pwrite  (1'b0),
    .paddr   ('0),
    .pwdata  ('0),
    .pready  (1'b0),
    .busy    (busy),
    .state   (state)
);

// ==== dcache_tb.sv ====
`include "dcache_params.svh"

module dcache_tb;

    localparam int          CLK_PERIOD = 40;
    localparam int          RESP_LIMIT = 100;
    localparam int          MEM_WORDS  = 64;
    localparam logic [31:0] FILL_KEY   = 32'hA5C3_0F96;
    localparam logic        LOAD       = 1'b0;
    localparam logic        STORE      = 1'b1;
    localparam logic        MISS       = 1'b0;
    localparam logic        HIT        = 1'b1;

    typedef struct {
        logic                is_store;
        dcache_pkg::access_t funct3;
        logic [31:0]         addr;
        logic [31:0]         wdata;
        logic                exp_hit;
        logic [31:0]         exp_data;
    } entry_t;

    logic                     clk;
    logic                     reset;
    logic [`DC_ADDR_BITS-1:0] addr;
    logic [31:0]              write_data;
    logic                     read_en;
    logic                     write_en;
    dcache_pkg::access_t      funct3;
    logic [31:0]              read_data;
    logic                     resp_valid;
    logic                     hit;
    logic                     busy;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [`DC_ADDR_BITS-1:0] paddr;
    logic [31:0]              pwdata;
    logic [31:0]              prdata;
    logic                     pready;

    // Expected values handed to the checker
    int          entry_idx;
    logic        exp_hit;
    logic [31:0] exp_data;
    logic        check_data;
    logic        finished;
    int          check_errors;
    int          assert_errors;

    entry_t      entries [$];
    bit          table_built;
    logic [31:0] mem [MEM_WORDS];   // APB memory model
    integer      seed;
    logic [1:0]  wait_left;
    logic [1:0]  wait_draw;

    tb_clkgen #(.PERIOD(CLK_PERIOD)) u_clkgen (.clk(clk), .reset(reset));

    dcache_top uut (
        .clk        (clk),
        .reset      (reset),
        .addr       (addr),
        .write_data (write_data),
        .read_en    (read_en),
        .write_en   (write_en),
        .funct3     (funct3),
        .read_data  (read_data),
        .resp_valid (resp_valid),
        .hit        (hit),
        .busy       (busy),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready)
    );

    dcache_checker #(.RESP_LIMIT(RESP_LIMIT)) u_checker (
        .clk           (clk),
        .reset         (reset),
        .read_en       (read_en),
        .write_en      (write_en),
        .resp_valid    (resp_valid),
        .hit           (hit),
        .read_data     (read_data),
        .busy          (busy),
        .entry_idx     (entry_idx),
        .exp_hit       (exp_hit),
        .exp_data      (exp_data),
        .check_data    (check_data),
        .finished      (finished),
        .assert_errors (assert_errors),
        .error_count   (check_errors)
    );

    assign assert_errors = uut.u_bridge.u_apb_props.fail_count
                         + uut.u_ctrl.u_ctrl_props.fail_count;

    task automatic add_entry(input logic is_store, input dcache_pkg::access_t f3,
                             input logic [31:0] a, input logic [31:0] wd,
                             input logic eh, input logic [31:0] ed);
        entry_t e;
        e.is_store = is_store;
        e.funct3   = f3;
        e.addr     = a;
        e.wdata    = wd;
        e.exp_hit  = eh;
        e.exp_data = ed;
        entries.push_back(e);
    endtask

    // Memory word at byte address a starts as a ^ A5C30F96
    task automatic build_table();
        add_entry(LOAD,  dcache_pkg::LW, 32'h00, 32'h0, MISS, 32'hA5C3_0F96);
        add_entry(LOAD,  dcache_pkg::LB, 32'h01, 32'h0, HIT,  32'h0000_000F);
        add_entry(LOAD,  dcache_pkg::LB, 32'h00, 32'h0, HIT,  32'hFFFF_FF96);
        add_entry(LOAD,  dcache_pkg::LH, 32'h02, 32'h0, HIT,  32'hFFFF_A5C3);
        add_entry(LOAD,  dcache_pkg::LH, 32'h04, 32'h0, HIT,  32'h0000_0F92);
        add_entry(LOAD,  dcache_pkg::LB, 32'h07, 32'h0, HIT,  32'hFFFF_FFA5);
        add_entry(LOAD,  dcache_pkg::LB, 32'h13, 32'h0, MISS, 32'hFFFF_FFA5);  // Set 1
        // Partial stores into the set 0 line
        add_entry(STORE, dcache_pkg::SB, 32'h09, 32'h0000_007F, HIT, 32'h0);
        add_entry(LOAD,  dcache_pkg::LW, 32'h08, 32'h0, HIT,  32'hA5C3_7F9E);
        add_entry(STORE, dcache_pkg::SH, 32'h0E, 32'hBEEF_8001, HIT, 32'h0);
        add_entry(LOAD,  dcache_pkg::LH, 32'h0E, 32'h0, HIT,  32'hFFFF_8001);
        add_entry(LOAD,  dcache_pkg::LW, 32'h0C, 32'h0, HIT,  32'h8001_0F9A);
        // Second and third tag in set 0
        add_entry(LOAD,  dcache_pkg::LW, 32'h24, 32'h0, MISS, 32'hA5C3_0FB2);
        add_entry(STORE, dcache_pkg::SW, 32'h20, 32'h1122_3344, HIT, 32'h0);
        add_entry(LOAD,  dcache_pkg::LW, 32'h48, 32'h0, MISS, 32'hA5C3_0FDE);  // Evicts tag 0
        add_entry(LOAD,  dcache_pkg::LW, 32'h08, 32'h0, MISS, 32'hA5C3_7F9E);  // Evicts tag 1
        add_entry(LOAD,  dcache_pkg::LW, 32'h0C, 32'h0, HIT,  32'h8001_0F9A);
        add_entry(LOAD,  dcache_pkg::LW, 32'h20, 32'h0, MISS, 32'h1122_3344);
        add_entry(LOAD,  dcache_pkg::LH, 32'h22, 32'h0, HIT,  32'h0000_1122);
        // Set 1 traffic
        add_entry(LOAD,  dcache_pkg::LB, 32'h16, 32'h0, HIT,  32'hFFFF_FFC3);
        add_entry(STORE, dcache_pkg::SB, 32'h10, 32'hFFFF_FF80, HIT, 32'h0);
        add_entry(LOAD,  dcache_pkg::LB, 32'h10, 32'h0, HIT,  32'hFFFF_FF80);
        add_entry(LOAD,  dcache_pkg::LW, 32'h30, 32'h0, MISS, 32'hA5C3_0FA6);
        add_entry(LOAD,  dcache_pkg::LW, 32'h50, 32'h0, MISS, 32'hA5C3_0FC6);
        add_entry(LOAD,  dcache_pkg::LB, 32'h10, 32'h0, MISS, 32'hFFFF_FF80);
        add_entry(STORE, dcache_pkg::SB, 32'h31, 32'h0000_005A, MISS, 32'h0);  // Store on miss
        add_entry(LOAD,  dcache_pkg::LW, 32'h30, 32'h0, HIT,  32'hA5C3_5AA6);
    endtask

    initial begin
        seed      = 32'h6b0532c8;
        pready    = 1'b0;
        prdata    = '0;
        wait_left = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (32'(i) << 2) ^ FILL_KEY;
        end
    end

    // APB memory with 0 to 3 wait states per transfer
    always @(posedge clk) begin
        if (reset) begin
            pready <= 1'b0;
        end else if (psel && !penable) begin
            wait_draw = 2'($random(seed));
            if (wait_draw == 2'd0) begin
                pready <= 1'b1;
                prdata <= mem[paddr[7:2]];
            end else begin
                pready    <= 1'b0;
                wait_left <= wait_draw;
            end
        end else if (psel && penable) begin
            if (pready) begin
                pready <= 1'b0;     // Transfer completes on this edge
                if (pwrite) begin
                    mem[paddr[7:2]] <= pwdata;
                end
            end else if (wait_left == 2'd1) begin
                pready <= 1'b1;
                prdata <= mem[paddr[7:2]];
            end else begin
                wait_left <= wait_left - 1'b1;
            end
        end
    end

    initial begin : stimulus
        entry_t e;
        int     waited;
        read_en    = 1'b0;
        write_en   = 1'b0;
        addr       = '0;
        write_data = '0;
        funct3     = dcache_pkg::LW;
        entry_idx  = 0;
        exp_hit    = 1'b0;
        exp_data   = '0;
        check_data = 1'b0;
        finished   = 1'b0;
        build_table();
        table_built = 1'b1;
        @(posedge clk);
        while (reset) begin
            @(posedge clk);
        end
        for (int i = 0; i < entries.size(); i++) begin
            e = entries[i];
            addr       <= e.addr;
            funct3     <= e.funct3;
            write_data <= e.wdata;
            read_en    <= !e.is_store;
            write_en   <= e.is_store;
            entry_idx  <= i;
            exp_hit    <= e.exp_hit;
            exp_data   <= e.exp_data;
            check_data <= !e.is_store;      // Stores return no data
            @(posedge clk);
            read_en  <= 1'b0;
            write_en <= 1'b0;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!resp_valid && waited < RESP_LIMIT + 5);
        end
        repeat (3) @(posedge clk);
        finished <= 1'b1;
        repeat (2) @(posedge clk);
        if (check_errors == 0 && assert_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_built);
        #(entries.size() * 40 * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", entries.size() * 40);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
dcache_pkg.sv
dcache_align.sv
dcache_ctrl.sv
dcache_apb_bridge.sv
dcache_top.sv
tb_clkgen.sv
dcache_checker.sv
dcache_props.sv
dcache_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = dcache_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(filter-out +incdir+%,$(shell cat $(FILELIST))) dcache_params.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
